//--- hw/vdp_pkg.sv
/*
 * shared definitions of the video display processor core
 * register map, bus and counter widths, and the structs passed between blocks
 */

package vdp_pkg;

    localparam int REG_ADDR_W  = 6;
    localparam int DATA_W      = 16;
    localparam int VRAM_ADDR_W = 14;
    localparam int PAL_ADDR_W  = 8;
    localparam int RASTER_X_W  = 12;
    localparam int RASTER_Y_W  = 11;
    localparam int SLOT_W      = 3;

    // writes and reads share the low addresses
    typedef enum logic [REG_ADDR_W-1:0] {
        reg_raster_x     = 6'h00,
        reg_pal_addr     = 6'h02,
        reg_pal_data     = 6'h03,
        reg_vram_addr    = 6'h04,
        reg_vram_data    = 6'h05,
        reg_vram_incr    = 6'h06,
        reg_display_ctrl = 6'h20,
        reg_target_x     = 6'h23,
        reg_target_y     = 6'h24
    } reg_addr_e;

    // read-side alias of the palette pointer address
    localparam reg_addr_e reg_raster_y = reg_pal_addr;

    typedef struct packed {
        logic [RASTER_X_W-1:0] x;
        logic [RASTER_Y_W-1:0] y;
    } raster_pos_t;

    typedef struct packed {
        logic [15:0]       addr;
        logic [DATA_W-1:0] data;
        logic              write;
    } host_req_t;

    typedef struct packed {
        reg_addr_e         addr;
        logic [DATA_W-1:0] data;
        logic              write;
    } reg_access_t;

    // lane_mask bit 0 selects the even port, bit 1 the odd port
    typedef struct packed {
        logic [VRAM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
        logic [1:0]             lane_mask;
    } vram_write_t;

    typedef struct packed {
        logic [VRAM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
        logic                   we;
    } vram_port_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

//--- hw/vdp_video_timing.sv
/*
 * raster timing generator
 * x/y counters, active-low syncs, active display and line/frame strobes
 */

`timescale 1ns/1ps

module vdp_video_timing #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 11,
    parameter int v_sync   = 2,
    parameter int v_back   = 31
) (
    input  logic                 clk,
    input  logic                 sprites_x_reset,
    output vdp_pkg::raster_pos_t raster,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 active_display,
    output logic                 line_ended,
    output logic                 frame_ended
);
    import vdp_pkg::*;

    localparam int h_total     = h_active + h_front + h_sync + h_back;
    localparam int v_total     = v_active + v_front + v_sync + v_back;
    localparam int hsync_start = h_active + h_front;
    localparam int vsync_start = v_active + v_front;

    logic [RASTER_X_W-1:0] x_count;
    logic [RASTER_Y_W-1:0] y_count;

    always_ff @(posedge clk) begin
        if (sprites_x_reset) begin
            x_count <= '0;
            y_count <= '0;
        end else if (line_ended) begin
            x_count <= '0;
            y_count <= frame_ended ? '0 : y_count + 1'b1;
        end else begin
            x_count <= x_count + 1'b1;
        end
    end

    assign raster = '{x: x_count, y: y_count};

    // strobes sit on the last cycle of a line or frame
    assign line_ended  = x_count == RASTER_X_W'(h_total - 1);
    assign frame_ended = line_ended && (y_count == RASTER_Y_W'(v_total - 1));

    assign active_display = (x_count < RASTER_X_W'(h_active)) &&
                            (y_count < RASTER_Y_W'(v_active));

    // sync pulses are active low
    assign hsync = !((x_count >= RASTER_X_W'(hsync_start)) &&
                     (x_count < RASTER_X_W'(hsync_start + h_sync)));
    assign vsync = !((y_count >= RASTER_Y_W'(vsync_start)) &&
                     (y_count < RASTER_Y_W'(vsync_start + v_sync)));

endmodule

//--- hw/vdp_host_port.sv
/*
 * four-phase req/ack host port
 * latches the host payload, issues one register strobe and holds ack until req drops
 */

`timescale 1ns/1ps

module vdp_host_port (
    input  logic                 clk,
    input  logic                 sprites_x_reset,
    input  logic                 req,
    input  vdp_pkg::host_req_t   host,
    input  logic                 access_done,
    output logic                 ack,
    output vdp_pkg::reg_access_t access,
    output logic                 access_strobe
);
    import vdp_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait_done,
        st_hold_ack
    } state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (sprites_x_reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    state <= st_wait_done;
                end
                // vram_data writes can sit here until their slot comes round
                st_wait_done: begin
                    if (access_done) begin
                        state <= st_hold_ack;
                    end
                end
                st_hold_ack: begin
                    if (!req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload captured once when the request is first seen
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            access.addr  <= reg_addr_e'(host.addr[REG_ADDR_W-1:0]);
            access.data  <= host.data;
            access.write <= host.write;
        end
    end

    assign access_strobe = state == st_issue;
    assign ack           = state == st_hold_ack;

endmodule

//--- hw/vdp_register_file.sv
/*
 * register file
 * write decode, palette and VRAM pointers with auto-increment,
 * raster target compare and the registered raster read mux
 */

`timescale 1ns/1ps

module vdp_register_file (
    input  logic                                 clk,
    input  logic                                 sprites_x_reset,
    input  vdp_pkg::reg_access_t                 access,
    input  logic                                 access_strobe,
    input  vdp_pkg::raster_pos_t                 raster,
    input  logic                                 write_taken,
    output logic                                 access_done,
    output logic [vdp_pkg::DATA_W-1:0]           read_data,
    output vdp_pkg::vram_write_t                 vram_write,
    output logic                                 vram_pending,
    output logic                                 pal_we,
    output logic [vdp_pkg::PAL_ADDR_W-1:0]       pal_waddr,
    output logic [vdp_pkg::DATA_W-1:0]           pal_wdata,
    output logic                                 display_enable,
    output logic                                 target_raster_hit
);
    import vdp_pkg::*;

    // byte pointer, bit 0 picks the lane
    logic [VRAM_ADDR_W:0]  vram_ptr;
    logic [7:0]            vram_incr;
    logic [RASTER_X_W-1:0] target_x;
    logic [RASTER_Y_W-1:0] target_y;
    logic                  reg_done;
    logic                  write_strobe;
    logic                  read_strobe;
    logic                  vram_data_write;
    logic                  pal_data_write;

    assign write_strobe    = access_strobe && access.write;
    assign read_strobe     = access_strobe && !access.write;
    assign vram_data_write = write_strobe && (access.addr == reg_vram_data);
    assign pal_data_write  = write_strobe && (access.addr == reg_pal_data);

    // a vram_data write only completes once the sequencer has committed it
    assign access_done = reg_done || write_taken;

    always_ff @(posedge clk) begin
        if (sprites_x_reset) begin
            reg_done          <= 1'b0;
            vram_pending      <= 1'b0;
            pal_we            <= 1'b0;
            pal_waddr         <= '0;
            vram_ptr          <= '0;
            vram_incr         <= 8'd1;
            display_enable    <= 1'b0;
            target_x          <= '0;
            target_y          <= '0;
            target_raster_hit <= 1'b0;
        end else begin
            reg_done          <= access_strobe && !vram_data_write;
            pal_we            <= pal_data_write;
            target_raster_hit <= (raster.x == target_x) && (raster.y == target_y);

            // step to the next entry once the previous write has landed
            if (pal_we) begin
                pal_waddr <= pal_waddr + 1'b1;
            end
            if (write_taken) begin
                vram_pending <= 1'b0;
            end

            if (write_strobe) begin
                case (access.addr)
                    reg_pal_addr:     pal_waddr <= access.data[PAL_ADDR_W-1:0];
                    reg_vram_addr:    vram_ptr <= access.data[VRAM_ADDR_W:0];
                    reg_vram_data: begin
                        vram_pending <= 1'b1;
                        vram_ptr     <= vram_ptr + (VRAM_ADDR_W + 1)'(vram_incr);
                    end
                    reg_vram_incr:    vram_incr <= access.data[7:0];
                    reg_display_ctrl: display_enable <= access.data[0];
                    reg_target_x:     target_x <= access.data[RASTER_X_W-1:0];
                    reg_target_y:     target_y <= access.data[RASTER_Y_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pal_data_write) begin
            pal_wdata <= access.data;
        end
        if (vram_data_write) begin
            vram_write.addr      <= vram_ptr[VRAM_ADDR_W:1];
            vram_write.data      <= access.data;
            vram_write.lane_mask <= vram_ptr[0] ? 2'b10 : 2'b01;
        end
        // raster position as seen in the strobe cycle
        if (read_strobe) begin
            case (access.addr)
                reg_raster_x: read_data <= DATA_W'(raster.x);
                reg_raster_y: read_data <= DATA_W'(raster.y);
                default:      read_data <= '0;
            endcase
        end
    end

endmodule

//--- hw/vdp_vram_sequencer.sv
/*
 * VRAM access sequencer
 * issues the pending host write on the reserved slot of every 8 raster cycles
 */

`timescale 1ns/1ps

module vdp_vram_sequencer (
    input  logic                 clk,
    input  logic                 sprites_x_reset,
    input  vdp_pkg::raster_pos_t raster,
    input  vdp_pkg::vram_write_t vram_write,
    input  logic                 vram_pending,
    output logic                 write_taken,
    output vdp_pkg::vram_port_t  vram_even,
    output vdp_pkg::vram_port_t  vram_odd
);
    import vdp_pkg::*;

    // last slot of the sequence belongs to the host, the others are idle
    localparam logic [SLOT_W-1:0] host_slot = '1;

    logic [SLOT_W-1:0] slot;
    logic              issue;

    assign slot  = raster.x[SLOT_W-1:0];
    assign issue = (slot == host_slot) && vram_pending;

    always_ff @(posedge clk) begin
        // address and data held between host slots
        if (issue) begin
            vram_even.addr <= vram_write.addr;
            vram_even.data <= vram_write.data;
            vram_odd.addr  <= vram_write.addr;
            vram_odd.data  <= vram_write.data;
        end

        if (sprites_x_reset) begin
            write_taken  <= 1'b0;
            vram_even.we <= 1'b0;
            vram_odd.we  <= 1'b0;
        end else begin
            // write_taken lines up with the we pulse on the port
            write_taken  <= issue;
            vram_even.we <= issue && vram_write.lane_mask[0];
            vram_odd.we  <= issue && vram_write.lane_mask[1];
        end
    end

endmodule

//--- hw/vdp_palette_ram.sv
/*
 * palette memory, 256 x 16
 * entry 0 is the backdrop colour driven to rgb during active display
 */

`timescale 1ns/1ps

module vdp_palette_ram (
    input  logic                           clk,
    input  logic                           pal_we,
    input  logic [vdp_pkg::PAL_ADDR_W-1:0] pal_waddr,
    input  logic [vdp_pkg::DATA_W-1:0]     pal_wdata,
    input  logic                           display_enable,
    input  logic                           active_display,
    output vdp_pkg::rgb_t                  rgb
);
    import vdp_pkg::*;

    logic [DATA_W-1:0] pal_mem [2**PAL_ADDR_W];
    logic [DATA_W-1:0] backdrop;
    logic              active_d;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[pal_waddr] <= pal_wdata;
        end

        // first stage, lookup and active delayed to match
        backdrop <= pal_mem[0];
        active_d <= active_display;

        // second stage, blank outside the display area
        rgb <= (display_enable && active_d) ? rgb_t'(backdrop[$bits(rgb_t)-1:0]) : '0;
    end

endmodule

//--- hw/vdp_top.sv
/*
 * video display processor core, top level
 * timing, host port, register file, VRAM sequencer and palette
 */

`timescale 1ns/1ps

module vdp_top #(
    // 640x480 timing
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 11,
    parameter int v_sync   = 2,
    parameter int v_back   = 31
) (
    input  logic                       clk,
    input  logic                       sprites_x_reset,
    input  logic                       req,
    input  vdp_pkg::host_req_t         host,
    output logic                       ack,
    output logic [vdp_pkg::DATA_W-1:0] read_data,
    output vdp_pkg::rgb_t              rgb,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       active_display,
    output logic                       line_ended,
    output logic                       frame_ended,
    output logic                       target_raster_hit,
    output vdp_pkg::vram_port_t        vram_even,
    output vdp_pkg::vram_port_t        vram_odd
);
    import vdp_pkg::*;

    raster_pos_t             raster;
    reg_access_t             access;
    logic                    access_strobe;
    logic                    access_done;
    vram_write_t             vram_write;
    logic                    vram_pending;
    logic                    write_taken;
    logic                    pal_we;
    logic [PAL_ADDR_W-1:0]   pal_waddr;
    logic [DATA_W-1:0]       pal_wdata;
    logic                    display_enable;

    vdp_video_timing #(
        .h_active(h_active),
        .h_front(h_front),
        .h_sync(h_sync),
        .h_back(h_back),
        .v_active(v_active),
        .v_front(v_front),
        .v_sync(v_sync),
        .v_back(v_back)
    ) video_timing_i (
        .clk(clk),
        .sprites_x_reset(sprites_x_reset),
        .raster(raster),
        .hsync(hsync),
        .vsync(vsync),
        .active_display(active_display),
        .line_ended(line_ended),
        .frame_ended(frame_ended)
    );

    vdp_host_port host_port_i (
        .clk(clk),
        .sprites_x_reset(sprites_x_reset),
        .req(req),
        .host(host),
        .access_done(access_done),
        .ack(ack),
        .access(access),
        .access_strobe(access_strobe)
    );

    vdp_register_file register_file_i (
        .clk(clk),
        .sprites_x_reset(sprites_x_reset),
        .access(access),
        .access_strobe(access_strobe),
        .raster(raster),
        .write_taken(write_taken),
        .access_done(access_done),
        .read_data(read_data),
        .vram_write(vram_write),
        .vram_pending(vram_pending),
        .pal_we(pal_we),
        .pal_waddr(pal_waddr),
        .pal_wdata(pal_wdata),
        .display_enable(display_enable),
        .target_raster_hit(target_raster_hit)
    );

    vdp_vram_sequencer vram_sequencer_i (
        .clk(clk),
        .sprites_x_reset(sprites_x_reset),
        .raster(raster),
        .vram_write(vram_write),
        .vram_pending(vram_pending),
        .write_taken(write_taken),
        .vram_even(vram_even),
        .vram_odd(vram_odd)
    );

    vdp_palette_ram palette_ram_i (
        .clk(clk),
        .pal_we(pal_we),
        .pal_waddr(pal_waddr),
        .pal_wdata(pal_wdata),
        .display_enable(display_enable),
        .active_display(active_display),
        .rgb(rgb)
    );

endmodule

//--- tb/vdp_tb_tasks.svh
/*
 * testbench tasks for the video display processor core
 * compare tasks, four-phase host access and the directed tests
 */

`ifndef vdp_tb_tasks_svh
`define vdp_tb_tasks_svh

task automatic report_error(input string msg);
    error_count++;
    $display("error at %0t: %s", $time, msg);
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_data(input string what, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_vram(input string what, input vram_port_t got, input vram_port_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s got addr %h data %h we %b, expected addr %h data %h we %b",
                 $time, what, got.addr, got.data, got.we, exp.addr, exp.data, exp.we);
    end
endtask

task automatic check_rgb(input string what, input rgb_t got, input rgb_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d errors", name, error_count - errors_before);
    end
endtask

// one full req/ack cycle, outputs are sampled just before each rising edge
task automatic host_access(input reg_addr_e target_reg, input logic [DATA_W-1:0] wdata,
                           input logic is_write, output logic [DATA_W-1:0] rdata,
                           output int unsigned start_cycle, output int unsigned ack_cycle);
    @(posedge clk);
    req  <= 1'b1;
    host <= '{addr: 16'(target_reg), data: wdata, write: is_write};
    start_cycle = cycle_count;
    do begin
        @(posedge clk);
    end while (ack !== 1'b1);
    ack_cycle = cycle_count;
    rdata = read_data;
    req <= 1'b0;
    do begin
        @(posedge clk);
    end while (ack !== 1'b0);
endtask

task automatic host_write(input reg_addr_e target_reg, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] rdata;
    int unsigned       start_cycle;
    int unsigned       ack_cycle;
    host_access(target_reg, wdata, 1'b1, rdata, start_cycle, ack_cycle);
endtask

task automatic wait_frame_end();
    do begin
        @(posedge clk);
    end while (frame_ended !== 1'b1);
endtask

task automatic wait_target_hit();
    do begin
        @(posedge clk);
    end while (target_raster_hit !== 1'b1);
endtask

// one vram_data write, then exactly one we pulse on the lane of byte address bit 0
task automatic vram_write_check(input logic [ptr_w-1:0] byte_addr,
                                input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] rdata;
    int unsigned       start_cycle;
    int unsigned       ack_cycle;
    vram_port_t        expected;
    vram_port_t        got;
    expected = '{addr: byte_addr[ptr_w-1:1], data: wdata, we: 1'b1};
    host_access(reg_vram_data, wdata, 1'b1, rdata, start_cycle, ack_cycle);
    if ((byte_addr[0] && (odd_q.size() != 1 || even_q.size() != 0)) ||
        (!byte_addr[0] && (even_q.size() != 1 || odd_q.size() != 0))) begin
        report_error($sformatf("byte address %h gave %0d even and %0d odd we pulses",
                               byte_addr, even_q.size(), odd_q.size()));
        even_q.delete();
        odd_q.delete();
    end else begin
        got = byte_addr[0] ? odd_q.pop_front() : even_q.pop_front();
        check_vram("vram write", got, expected);
        if (last_we_cycle <= start_cycle || last_we_cycle >= ack_cycle) begin
            report_error("ack of a vram_data write did not follow its we pulse");
        end
    end
endtask

// follows the raster from a frame boundary
// rgb shows the state of active display from two cycles before
task automatic check_rgb_frame(input rgb_t color, input logic enabled);
    int   x;
    int   y;
    logic act_exp;
    logic hs_exp;
    logic vs_exp;
    logic act_q1;
    logic act_q2;
    rgb_t expected;
    wait_frame_end();
    // the last line of a frame is vertical blanking
    act_q1 = 1'b0;
    act_q2 = 1'b0;
    for (int i = 0; i < frame_cycles; i++) begin
        @(posedge clk);
        x = i % h_total;
        y = i / h_total;
        act_exp = (x < h_active) && (y < v_active);
        hs_exp  = !((x >= h_active + h_front) && (x < h_active + h_front + h_sync));
        vs_exp  = !((y >= v_active + v_front) && (y < v_active + v_front + v_sync));
        check_flag("active display", active_display, act_exp);
        check_flag("hsync", hsync, hs_exp);
        check_flag("vsync", vsync, vs_exp);
        expected = (enabled && act_q2) ? color : '0;
        check_rgb("backdrop colour", rgb, expected);
        act_q2 = act_q1;
        act_q1 = act_exp;
    end
endtask

task automatic test_reset_and_timing();
    int                errors_before;
    logic [DATA_W-1:0] x1;
    logic [DATA_W-1:0] x2;
    int unsigned       c1;
    int unsigned       c2;
    int unsigned       a1;
    int unsigned       a2;
    int unsigned       lines_before;
    errors_before = error_count;
    @(posedge clk);
    check_flag("ack after reset", ack, 1'b0);
    check_flag("even we after reset", vram_even.we, 1'b0);
    check_flag("odd we after reset", vram_odd.we, 1'b0);
    check_rgb("rgb after reset", rgb, '0);
    host_access(reg_raster_x, '0, 1'b0, x1, c1, a1);
    check_data("read ack latency", DATA_W'(a1 - c1), DATA_W'(ack_latency));
    repeat ($urandom_range(1, 40)) @(posedge clk);
    host_access(reg_raster_x, '0, 1'b0, x2, c2, a2);
    check_data("raster_x advance", x2, DATA_W'((32'(x1) + c2 - c1) % h_total));
    wait_frame_end();
    lines_before = line_count;
    wait_frame_end();
    check_data("lines per frame", DATA_W'(line_count - lines_before), DATA_W'(v_total));
    finish_test("reset and timing", errors_before);
endtask

task automatic test_vram_writes();
    int                errors_before;
    logic [ptr_w-1:0]  ptr;
    logic [7:0]        incr;
    errors_before = error_count;
    // first pass starts on an even byte address, second on an odd one
    for (int pass = 0; pass < 2; pass++) begin
        incr = 8'($urandom_range(1, 7));
        ptr = ptr_w'($urandom);
        ptr[0] = pass[0];
        host_write(reg_vram_incr, DATA_W'(incr));
        host_write(reg_vram_addr, DATA_W'(ptr));
        for (int n = 0; n < 3; n++) begin
            vram_write_check(ptr, DATA_W'($urandom));
            ptr = ptr + ptr_w'(incr);
        end
    end
    finish_test("vram writes", errors_before);
endtask

task automatic test_palette_backdrop();
    int                errors_before;
    logic [DATA_W-1:0] entries [4];
    logic [DATA_W-1:0] new_entry0;
    errors_before = error_count;
    host_write(reg_pal_addr, '0);
    // low nibble keeps the entries distinct and non-zero
    foreach (entries[i]) begin
        entries[i] = (DATA_W'($urandom) & 16'hfff0) | DATA_W'(i + 1);
        host_write(reg_pal_data, entries[i]);
    end
    check_rgb_frame(rgb_t'(entries[0][11:0]), 1'b0);
    host_write(reg_display_ctrl, 16'h0001);
    check_rgb_frame(rgb_t'(entries[0][11:0]), 1'b1);
    new_entry0 = (DATA_W'($urandom) & 16'hfff0) | 16'h0009;
    host_write(reg_pal_addr, '0);
    host_write(reg_pal_data, new_entry0);
    check_rgb_frame(rgb_t'(new_entry0[11:0]), 1'b1);
    host_write(reg_display_ctrl, '0);
    check_rgb_frame(rgb_t'(new_entry0[11:0]), 1'b0);
    finish_test("palette backdrop", errors_before);
endtask

task automatic test_raster_target();
    int                errors_before;
    int unsigned       hits_before;
    logic [DATA_W-1:0] rdata;
    int unsigned       start_cycle;
    int unsigned       ack_cycle;
    errors_before = error_count;
    host_write(reg_target_x, DATA_W'(tgt_x));
    host_write(reg_target_y, DATA_W'(tgt_y));
    wait_frame_end();
    hits_before = hit_count;
    wait_frame_end();
    check_data("target hits per frame", DATA_W'(hit_count - hits_before), 16'd1);
    wait_target_hit();
    host_access(reg_raster_x, '0, 1'b0, rdata, start_cycle, ack_cycle);
    check_data("raster_x after hit", rdata, DATA_W'((tgt_x + read_delay) % h_total));
    wait_target_hit();
    host_access(reg_raster_y, '0, 1'b0, rdata, start_cycle, ack_cycle);
    check_data("raster_y after hit", rdata, DATA_W'(tgt_y));
    finish_test("raster target", errors_before);
endtask

task automatic test_back_to_back_vram();
    int               errors_before;
    logic [ptr_w-1:0] ptr;
    errors_before = error_count;
    ptr = ptr_w'($urandom);
    host_write(reg_vram_incr, 16'd1);
    host_write(reg_vram_addr, DATA_W'(ptr));
    for (int n = 0; n < 6; n++) begin
        vram_write_check(ptr, DATA_W'($urandom));
        ptr = ptr + 1'b1;
    end
    repeat (16) @(posedge clk);
    if (even_q.size() != 0 || odd_q.size() != 0) begin
        report_error("a VRAM write was repeated after its host access ended");
    end
    finish_test("back-to-back vram", errors_before);
endtask

`endif

//--- tb/tb_vdp.sv
/*
 * testbench for the video display processor core
 * clock, reset, DUT, VRAM and strobe monitors, timeout and test sequence
 */

`timescale 1ns/1ps

module tb_vdp;
    import vdp_pkg::*;

    // small raster of 24 x 9 for a short run
    localparam int h_active       = 16;
    localparam int h_front        = 4;
    localparam int h_sync         = 2;
    localparam int h_back         = 2;
    localparam int v_active       = 6;
    localparam int v_front        = 1;
    localparam int v_sync         = 1;
    localparam int v_back         = 1;
    localparam int h_total        = h_active + h_front + h_sync + h_back;
    localparam int v_total        = v_active + v_front + v_sync + v_back;
    localparam int frame_cycles   = h_total * v_total;
    localparam int timeout_cycles = 20 * frame_cycles;
    localparam int ptr_w          = VRAM_ADDR_W + 1;
    // drive edge, DUT sample edge, then two cycles to ack
    localparam int ack_latency    = 4;
    // cycles from the target position to the raster value a read captures
    localparam int read_delay     = 4;
    localparam int tgt_x          = 5;
    localparam int tgt_y          = 3;
    localparam logic [31:0] rand_seed = 32'ha8e7_d563;

    logic              clk;
    logic              sprites_x_reset;
    logic              req;
    host_req_t         host;
    logic              ack;
    logic [DATA_W-1:0] read_data;
    rgb_t              rgb;
    logic              hsync;
    logic              vsync;
    logic              active_display;
    logic              line_ended;
    logic              frame_ended;
    logic              target_raster_hit;
    vram_port_t        vram_even;
    vram_port_t        vram_odd;

    int unsigned cycle_count   = 0;
    int unsigned line_count    = 0;
    int unsigned hit_count     = 0;
    int unsigned last_we_cycle = 0;
    vram_port_t  even_q [$];
    vram_port_t  odd_q [$];
    int          error_count   = 0;
    int          check_count   = 0;
    int          test_count    = 0;

    vdp_top #(
        .h_active(h_active),
        .h_front(h_front),
        .h_sync(h_sync),
        .h_back(h_back),
        .v_active(v_active),
        .v_front(v_front),
        .v_sync(v_sync),
        .v_back(v_back)
    ) vdp_top_i (
        .clk(clk),
        .sprites_x_reset(sprites_x_reset),
        .req(req),
        .host(host),
        .ack(ack),
        .read_data(read_data),
        .rgb(rgb),
        .hsync(hsync),
        .vsync(vsync),
        .active_display(active_display),
        .line_ended(line_ended),
        .frame_ended(frame_ended),
        .target_raster_hit(target_raster_hit),
        .vram_even(vram_even),
        .vram_odd(vram_odd)
    );

    always #10 clk = ~clk;

    // counters and VRAM write capture, all sampled at the rising edge
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (line_ended) begin
            line_count <= line_count + 1;
        end
        if (target_raster_hit) begin
            hit_count <= hit_count + 1;
        end
        if (vram_even.we) begin
            even_q.push_back(vram_even);
            last_we_cycle <= cycle_count;
        end
        if (vram_odd.we) begin
            odd_q.push_back(vram_odd);
            last_we_cycle <= cycle_count;
        end
    end

    `include "vdp_tb_tasks.svh"

    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
        end
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        sprites_x_reset = 1'b1;
        req             = 1'b0;
        host            = '0;
        void'($urandom(rand_seed));
        repeat (10) @(posedge clk);
        sprites_x_reset <= 1'b0;

        test_reset_and_timing();
        test_vram_writes();
        test_palette_backdrop();
        test_raster_target();
        test_back_to_back_vram();

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+tb
hw/vdp_pkg.sv
hw/vdp_video_timing.sv
hw/vdp_host_port.sv
hw/vdp_register_file.sv
hw/vdp_vram_sequencer.sv
hw/vdp_palette_ram.sv
hw/vdp_top.sv
tb/tb_vdp.sv

//--- Makefile
# Verilator build and run of the VDP core testbench

VERILATOR ?= verilator
TOP       ?= tb_vdp
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
